// ==== cache_cfg_pkg.sv ====
`default_nettype none

package cache_cfg_pkg;

	// Width of a CPU word address.
	localparam int addr_width = 10;

	// Width of one data word, which is also one cache line.
	localparam int data_width = 32;

	// Index bits select one of the lines.
	localparam int index_width = 4;

	// The tag holds the address bits above the index.
	localparam int tag_width = addr_width - index_width;

	// Number of lines in the direct-mapped store.
	localparam int num_lines = 1 << index_width;

endpackage

`default_nettype wire

// ==== cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

	import cache_cfg_pkg::*;

	// CPU opcodes.
	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} cache_op_e;

	// Controller states.
	typedef enum logic [3:0] {
		st_idle           = 4'd0,
		st_lookup         = 4'd1,
		st_write_back     = 4'd2,
		st_write_back_mem = 4'd3,
		st_read_mem       = 4'd4,
		st_fill           = 4'd5,
		st_write_hit      = 4'd6,
		st_done           = 4'd7
	} cache_state_e;

	// One CPU request, held stable while cpu_req_valid is high.
	typedef struct packed {
		cache_op_e             op;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
	} cpu_req_t;

	// One DRAM request, held stable while dram_req_valid is high.
	typedef struct packed {
		logic                  we;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
	} dram_req_t;

endpackage

`default_nettype wire

// ==== cache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_store (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [cache_cfg_pkg::index_width-1:0] index,
	input  logic [cache_cfg_pkg::tag_width-1:0]   tag,
	input  logic                                  we,
	input  logic [cache_cfg_pkg::data_width-1:0]  wdata,
	input  logic                                  dirty_in,
	output logic                                  hit,
	output logic                                  victim_valid,
	output logic                                  victim_dirty,
	output logic [cache_cfg_pkg::tag_width-1:0]   victim_tag,
	output logic [cache_cfg_pkg::data_width-1:0]  victim_data
);
	import cache_cfg_pkg::*;

	// Per-line status bits.
	logic [num_lines-1:0] valid_q;
	logic [num_lines-1:0] dirty_q;

	// Tag and data arrays.
	logic [tag_width-1:0]  tag_mem  [num_lines];
	logic [data_width-1:0] data_mem [num_lines];

	// Status bits are cleared on reset so every line starts invalid.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (we)
		begin
			valid_q[index] <= 1'b1;
			dirty_q[index] <= dirty_in;
		end
	end

	// A write replaces the whole line at the index.
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			tag_mem[index]  <= tag;
			data_mem[index] <= wdata;
		end
	end

	// Asynchronous read of the addressed line.
	assign victim_valid = valid_q[index];
	assign victim_dirty = dirty_q[index];
	assign victim_tag   = tag_mem[index];
	assign victim_data  = data_mem[index];

	// Hit needs a valid line whose tag matches the request.
	assign hit = victim_valid && (victim_tag == tag);

endmodule

`default_nettype wire

// ==== l1_cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_cache_controller (
	input  logic                                 clk,
	input  logic                                 rst,
	input  cache_ctrl_pkg::cpu_req_t             cpu_req,
	input  logic                                 cpu_req_valid,
	output logic                                 cpu_ack,
	output logic [cache_cfg_pkg::data_width-1:0] cpu_rdata,
	output logic [cache_cfg_pkg::addr_width-1:0] req_addr,
	input  logic                                 hit,
	input  logic                                 victim_valid,
	input  logic                                 victim_dirty,
	input  logic [cache_cfg_pkg::data_width-1:0] victim_data,
	output logic                                 store_we,
	output logic [cache_cfg_pkg::data_width-1:0] store_wdata,
	output logic                                 store_dirty,
	output logic                                 wb_sel,
	output logic                                 dram_req_valid,
	output logic                                 dram_we,
	output logic [cache_cfg_pkg::data_width-1:0] dram_wdata,
	input  logic                                 dram_ack,
	input  logic [cache_cfg_pkg::data_width-1:0] dram_rdata
);
	import cache_ctrl_pkg::*;

	cache_state_e state;

	// Accepted CPU request.
	cpu_req_t req_q;

	assign req_addr = req_q.addr;

	// Main FSM.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state   <= st_idle;
			cpu_ack <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (cpu_req_valid)
						state <= st_lookup;

				st_lookup:
				begin
					if (hit)
						state <= (req_q.op == op_write) ? st_write_hit : st_done;
					else if (victim_valid && victim_dirty)
						state <= st_write_back;
					else if (req_q.op == op_write)
						state <= st_write_hit;
					else
						state <= st_read_mem;
				end

				// Dirty victim goes out first.
				st_write_back:
					if (dram_ack)
						state <= st_write_back_mem;

				// Wait for the DRAM to release its ack.
				st_write_back_mem:
				begin
					if (!dram_ack)
						state <= (req_q.op == op_write) ? st_write_hit : st_read_mem;
				end

				st_read_mem:
					if (dram_ack)
						state <= st_fill;

				// Line is installed once the ack is gone.
				st_fill:
					if (!dram_ack)
						state <= st_done;

				// Write hit and write miss install the same way.
				st_write_hit:
					state <= st_done;

				st_done:
				begin
					if (!cpu_ack)
						cpu_ack <= 1'b1;
					else if (!cpu_req_valid)
					begin
						cpu_ack <= 1'b0;
						state   <= st_idle;
					end
				end

				default:
					state <= st_idle;
			endcase
		end
	end

	// Request and read data registers.
	always_ff @(posedge clk)
	begin
		if (state == st_idle && cpu_req_valid)
			req_q <= cpu_req;

		if (state == st_lookup && hit)
			cpu_rdata <= victim_data;
		else if (state == st_read_mem && dram_ack)
			cpu_rdata <= dram_rdata;
	end

	// Store control. Fill data comes from the registered DRAM word.
	assign store_we    = (state == st_write_hit) || (state == st_fill && !dram_ack);
	assign store_wdata = (state == st_fill) ? cpu_rdata : req_q.wdata;
	assign store_dirty = (state == st_write_hit);

	// Victim address is used through the whole write-back.
	assign wb_sel = (state == st_write_back) || (state == st_write_back_mem);

	// DRAM request side.
	assign dram_req_valid = (state == st_write_back) || (state == st_read_mem);
	assign dram_we        = (state == st_write_back);
	assign dram_wdata     = victim_data;

endmodule

`default_nettype wire

// ==== l1_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_cache_top (
	input  logic                                 clk,
	input  logic                                 rst,
	input  cache_ctrl_pkg::cpu_req_t             cpu_req,
	input  logic                                 cpu_req_valid,
	output logic                                 cpu_ack,
	output logic [cache_cfg_pkg::data_width-1:0] cpu_rdata,
	output cache_ctrl_pkg::dram_req_t            dram_req,
	output logic                                 dram_req_valid,
	input  logic                                 dram_ack,
	input  logic [cache_cfg_pkg::data_width-1:0] dram_rdata
);
	import cache_cfg_pkg::*;

	logic [addr_width-1:0]  req_addr;
	logic [index_width-1:0] index;
	logic [tag_width-1:0]   tag;

	logic                  hit;
	logic                  victim_valid;
	logic                  victim_dirty;
	logic [tag_width-1:0]  victim_tag;
	logic [data_width-1:0] victim_data;

	logic                  store_we;
	logic [data_width-1:0] store_wdata;
	logic                  store_dirty;
	logic                  wb_sel;
	logic                  dram_we;
	logic [data_width-1:0] dram_wdata;

	// Split the registered request address.
	assign index = req_addr[index_width-1:0];
	assign tag   = req_addr[addr_width-1:index_width];

	l1_cache_controller l1_cache_controller_inst (
		.clk            (clk),
		.rst            (rst),
		.cpu_req        (cpu_req),
		.cpu_req_valid  (cpu_req_valid),
		.cpu_ack        (cpu_ack),
		.cpu_rdata      (cpu_rdata),
		.req_addr       (req_addr),
		.hit            (hit),
		.victim_valid   (victim_valid),
		.victim_dirty   (victim_dirty),
		.victim_data    (victim_data),
		.store_we       (store_we),
		.store_wdata    (store_wdata),
		.store_dirty    (store_dirty),
		.wb_sel         (wb_sel),
		.dram_req_valid (dram_req_valid),
		.dram_we        (dram_we),
		.dram_wdata     (dram_wdata),
		.dram_ack       (dram_ack),
		.dram_rdata     (dram_rdata)
	);

	cache_store cache_store_inst (
		.clk          (clk),
		.rst          (rst),
		.index        (index),
		.tag          (tag),
		.we           (store_we),
		.wdata        (store_wdata),
		.dirty_in     (store_dirty),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_data  (victim_data)
	);

	// Write-back goes to the victim's address, a fill to the request address.
	assign dram_req.we    = dram_we;
	assign dram_req.addr  = wb_sel ? {victim_tag, index} : req_addr;
	assign dram_req.wdata = dram_wdata;

endmodule

`default_nettype wire

// ==== tb_l1_cache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache_sva (
	input logic                                 clk,
	input logic                                 rst,
	input logic                                 cpu_req_valid,
	input logic                                 cpu_ack,
	input logic                                 dram_req_valid,
	input logic                                 dram_ack,
	input logic                                 dram_we,
	input logic [cache_cfg_pkg::data_width-1:0] dram_wdata,
	input logic [cache_cfg_pkg::addr_width-1:0] req_addr,
	input logic                                 wb_sel,
	input logic                                 store_we
);

	// Ack only answers a live request, seen at the edge that raised it.
	ack_needs_valid: assert property (@(posedge clk) disable iff (!rst)
		$rose(cpu_ack) |-> $past(cpu_req_valid))
		else $error("cpu_ack rose without cpu_req_valid");

	// The DRAM request holds until it is acknowledged.
	dram_req_stable: assert property (@(posedge clk) disable iff (!rst)
		(dram_req_valid && !dram_ack) |=> $stable({dram_we, dram_wdata, req_addr, wb_sel}))
		else $error("DRAM request changed before dram_ack");

	reset_outputs_low: assert property (@(posedge clk)
		(!rst && $past(!rst)) |-> (!cpu_ack && !dram_req_valid && !store_we))
		else $error("Control output high during reset");

endmodule

bind l1_cache_controller tb_l1_cache_sva tb_l1_cache_sva_inst (
	.clk            (clk),
	.rst            (rst),
	.cpu_req_valid  (cpu_req_valid),
	.cpu_ack        (cpu_ack),
	.dram_req_valid (dram_req_valid),
	.dram_ack       (dram_ack),
	.dram_we        (dram_we),
	.dram_wdata     (dram_wdata),
	.req_addr       (req_addr),
	.wb_sel         (wb_sel),
	.store_we       (store_we)
);

`default_nettype wire

// ==== tb_l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;
	import cache_cfg_pkg::*;
	import cache_ctrl_pkg::*;

	localparam int max_cycles = 20000;
	localparam int ack_limit  = 200;

	logic                  clk;
	logic                  rst;
	cpu_req_t              cpu_req;
	logic                  cpu_req_valid;
	logic                  cpu_ack;
	logic [data_width-1:0] cpu_rdata;
	dram_req_t             dram_req;
	logic                  dram_req_valid;
	logic                  dram_ack;
	logic [data_width-1:0] dram_rdata;

	// DRAM contents, CPU-visible shadow and DRAM traffic log.
	logic [data_width-1:0] dram_mem [1 << addr_width];
	logic [data_width-1:0] shadow   [1 << addr_width];
	int                    dram_reads;
	int                    dram_writes;
	logic [addr_width-1:0] last_wr_addr;
	logic [data_width-1:0] last_wr_data;

	// Expected tag, valid and dirty per index.
	logic [tag_width-1:0] m_tag   [num_lines];
	logic                 m_valid [num_lines];
	logic                 m_dirty [num_lines];

	int errors;
	int cycles;

	l1_cache_top l1_cache_top_inst (
		.clk            (clk),
		.rst            (rst),
		.cpu_req        (cpu_req),
		.cpu_req_valid  (cpu_req_valid),
		.cpu_ack        (cpu_ack),
		.cpu_rdata      (cpu_rdata),
		.dram_req       (dram_req),
		.dram_req_valid (dram_req_valid),
		.dram_ack       (dram_ack),
		.dram_rdata     (dram_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("Run stopped: cycle limit of %0d reached", max_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// Initial DRAM word, spread over every address bit.
	function automatic logic [data_width-1:0] pattern(input logic [addr_width-1:0] a);
		pattern = {a, 22'h0} ^ ({22'h0, a} * 32'h0001_9e37) ^ 32'hc0de_0000;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// DRAM model, answers after 1 to 8 cycles.
	initial
	begin
		int delay;
		dram_ack   = 1'b0;
		dram_rdata = '0;
		forever
		begin
			@(negedge clk);
			if (rst && dram_req_valid)
			begin
				delay = 1 + ($urandom % 8);
				repeat (delay - 1) @(negedge clk);
				if (dram_req.we)
				begin
					dram_mem[dram_req.addr] = dram_req.wdata;
					last_wr_addr = dram_req.addr;
					last_wr_data = dram_req.wdata;
					dram_writes++;
				end
				else
				begin
					dram_rdata = dram_mem[dram_req.addr];
					dram_reads++;
				end
				dram_ack = 1'b1;
				while (dram_req_valid)
					@(negedge clk);
				dram_ack = 1'b0;
			end
		end
	end

	// Four-phase CPU transaction, ack held for hold cycles.
	task automatic cpu_txn(input cache_op_e op, input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] wdata, input int hold,
			output logic [data_width-1:0] rdata);
		int n;
		cpu_req.op    = op;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cpu_req_valid = 1'b1;
		n = 0;
		while (!cpu_ack && n < ack_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!cpu_ack)
		begin
			$display("Timeout waiting for cpu_ack at address %h", addr);
			errors++;
		end
		rdata = cpu_rdata;
		for (int i = 0; i < hold; i++)
		begin
			@(negedge clk);
			check("cpu_ack", {31'h0, cpu_ack}, 32'h1);
		end
		cpu_req_valid = 1'b0;
		n = 0;
		while (cpu_ack && n < ack_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (cpu_ack)
		begin
			$display("Timeout waiting for cpu_ack to fall at address %h", addr);
			errors++;
		end
	endtask

	// Predicts the cache behavior, runs one access and checks it.
	task automatic access(input cache_op_e op, input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] wdata, input int hold);
		logic [index_width-1:0] idx;
		logic [tag_width-1:0]   tg;
		logic [addr_width-1:0]  wb_addr;
		logic [data_width-1:0]  rdata;
		int                     exp_reads;
		int                     exp_writes;
		logic                   wb;
		idx        = addr[index_width-1:0];
		tg         = addr[addr_width-1:index_width];
		exp_reads  = dram_reads;
		exp_writes = dram_writes;
		wb         = 1'b0;
		wb_addr    = '0;
		if (m_valid[idx] && m_tag[idx] == tg)
		begin
			if (op == op_write)
				m_dirty[idx] = 1'b1;
		end
		else
		begin
			if (m_valid[idx] && m_dirty[idx])
			begin
				wb = 1'b1;
				wb_addr = {m_tag[idx], idx};
				exp_writes++;
			end
			if (op == op_read)
				exp_reads++;
			m_valid[idx] = 1'b1;
			m_tag[idx]   = tg;
			m_dirty[idx] = (op == op_write);
		end
		cpu_txn(op, addr, wdata, hold, rdata);
		if (op == op_read)
			check("cpu_rdata", rdata, shadow[addr]);
		else
			shadow[addr] = wdata;
		check("dram_reads", 32'(dram_reads), 32'(exp_reads));
		check("dram_writes", 32'(dram_writes), 32'(exp_writes));
		if (wb)
		begin
			check("dram_req.addr", 32'(last_wr_addr), 32'(wb_addr));
			check("dram_req.wdata", last_wr_data, shadow[wb_addr]);
		end
	endtask

	task automatic test_first_read;
		access(op_read, 10'h013, '0, 0);
		access(op_read, 10'h013, '0, 0);
	endtask

	task automatic test_write_hit;
		access(op_write, 10'h013, 32'h1234_5678, 0);
		access(op_read, 10'h013, '0, 1);
	endtask

	// Same index 3, new tag, so the dirty line goes out first.
	task automatic test_dirty_evict;
		access(op_write, 10'h053, 32'hcafe_f00d, 0);
		access(op_read, 10'h013, '0, 0);
	endtask

	task automatic test_clean_evict;
		access(op_read, 10'h024, '0, 0);
		access(op_read, 10'h064, '0, 0);
	endtask

	task automatic test_random;
		for (int i = 0; i < 200; i++)
			access(($urandom % 2) ? op_write : op_read, 10'($urandom % 128), $urandom,
				$urandom % 3);
	endtask

	// Long holds, then ack must stay low with the request gone.
	task automatic test_ack_hold;
		int reads;
		for (int i = 0; i < 10; i++)
		begin
			access(($urandom % 2) ? op_write : op_read, 10'($urandom % 64), $urandom,
				2 + ($urandom % 5));
			reads = dram_reads;
			repeat (3)
			begin
				@(negedge clk);
				check("cpu_ack", {31'h0, cpu_ack}, 32'h0);
			end
			check("dram_reads", 32'(dram_reads), 32'(reads));
		end
	endtask

	initial
	begin
		void'($urandom(32'h7e69_6a88));
		errors        = 0;
		cycles        = 0;
		dram_reads    = 0;
		dram_writes   = 0;
		last_wr_addr  = '0;
		last_wr_data  = '0;
		rst           = 1'b0;
		cpu_req       = '0;
		cpu_req_valid = 1'b0;
		for (int a = 0; a < (1 << addr_width); a++)
		begin
			dram_mem[a] = pattern(10'(a));
			shadow[a]   = pattern(10'(a));
		end
		for (int i = 0; i < num_lines; i++)
		begin
			m_tag[i]   = '0;
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
		end
		repeat (10) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		test_first_read();
		test_write_hit();
		test_dirty_evict();
		test_clean_evict();
		test_random();
		test_ack_hold();
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
cache_cfg_pkg.sv
cache_ctrl_pkg.sv
cache_store.sv
l1_cache_controller.sv
l1_cache_top.sv
tb_l1_cache_sva.sv
tb_l1_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_l1_cache \
	-o sim_tb_l1_cache

./obj_dir/sim_tb_l1_cache | tee sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	exit 1
fi
exit 0
